// File: source/exe_pkg.sv
`default_nettype none

package exe_pkg;

    localparam int XLEN  = 32;
    localparam int WID_W = 2;
    localparam int REG_W = 5;

    // CSR addresses, carried in the low bits of imm
    localparam logic [11:0] CSR_CYCLE   = 12'hC00;
    localparam logic [11:0] CSR_INSTRET = 12'hC02;
    localparam logic [11:0] CSR_SCRATCH = 12'h340;

    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_LSU = 2'd1,
        UNIT_CSR = 2'd2,
        UNIT_MUL = 2'd3
    } unit_e;

    typedef enum logic [4:0] {
        OP_ADD    = 5'd0,
        OP_SUB    = 5'd1,
        OP_AND    = 5'd2,
        OP_OR     = 5'd3,
        OP_XOR    = 5'd4,
        OP_SLT    = 5'd5,
        OP_SLL    = 5'd6,
        OP_SRL    = 5'd7,
        OP_BEQ    = 5'd8,
        OP_BNE    = 5'd9,
        OP_JAL    = 5'd10,
        OP_EBREAK = 5'd11,
        OP_ECALL  = 5'd12,
        OP_LW     = 5'd13,
        OP_SW     = 5'd14,
        OP_CSRRW  = 5'd15,
        OP_CSRRS  = 5'd16,
        OP_MUL    = 5'd17,
        OP_MULH   = 5'd18
    } op_e;

endpackage

`default_nettype wire

// File: source/exe_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exe_req_if;
    import exe_pkg::*;

    logic             valid;
    logic             ready;
    logic [WID_W-1:0] wid;
    logic [XLEN-1:0]  pc;
    op_e              op;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  rs1;
    logic [XLEN-1:0]  rs2;
    logic [XLEN-1:0]  imm;

    modport master (output valid, wid, pc, op, rd, rs1, rs2, imm, input ready);
    modport slave  (input valid, wid, pc, op, rd, rs1, rs2, imm, output ready);
endinterface

interface exe_cmt_if;
    import exe_pkg::*;

    logic             valid;
    logic             ready;
    logic [WID_W-1:0] wid;
    logic [XLEN-1:0]  pc;
    logic [REG_W-1:0] rd;
    logic             wb;
    logic [XLEN-1:0]  data;

    modport master (output valid, wid, pc, rd, wb, data, input ready);
    modport slave  (input valid, wid, pc, rd, wb, data, output ready);
endinterface

`default_nettype wire

// File: source/exe_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module exe_dispatch (
    input  wire                        req_valid,
    input  wire exe_pkg::unit_e        req_unit,
    input  wire exe_pkg::op_e          req_op,
    input  wire [exe_pkg::WID_W-1:0]   req_wid,
    input  wire [exe_pkg::XLEN-1:0]    req_pc,
    input  wire [exe_pkg::REG_W-1:0]   req_rd,
    input  wire [exe_pkg::XLEN-1:0]    req_rs1,
    input  wire [exe_pkg::XLEN-1:0]    req_rs2,
    input  wire [exe_pkg::XLEN-1:0]    req_imm,
    output logic                       req_ready,
    output logic                       ebreak,
    exe_req_if.master                  alu_req,
    exe_req_if.master                  lsu_req,
    exe_req_if.master                  csr_req,
    exe_req_if.master                  mul_req
);
    import exe_pkg::*;

    assign alu_req.valid = req_valid && (req_unit == UNIT_ALU);
    assign lsu_req.valid = req_valid && (req_unit == UNIT_LSU);
    assign csr_req.valid = req_valid && (req_unit == UNIT_CSR);
    assign mul_req.valid = req_valid && (req_unit == UNIT_MUL);

    // Payload fans out to every unit, only valid is steered
    assign {alu_req.wid, alu_req.pc, alu_req.rd} = {req_wid, req_pc, req_rd};
    assign {lsu_req.wid, lsu_req.pc, lsu_req.rd} = {req_wid, req_pc, req_rd};
    assign {csr_req.wid, csr_req.pc, csr_req.rd} = {req_wid, req_pc, req_rd};
    assign {mul_req.wid, mul_req.pc, mul_req.rd} = {req_wid, req_pc, req_rd};

    assign alu_req.op = req_op;
    assign lsu_req.op = req_op;
    assign csr_req.op = req_op;
    assign mul_req.op = req_op;

    assign {alu_req.rs1, alu_req.rs2, alu_req.imm} = {req_rs1, req_rs2, req_imm};
    assign {lsu_req.rs1, lsu_req.rs2, lsu_req.imm} = {req_rs1, req_rs2, req_imm};
    assign {csr_req.rs1, csr_req.rs2, csr_req.imm} = {req_rs1, req_rs2, req_imm};
    assign {mul_req.rs1, mul_req.rs2, mul_req.imm} = {req_rs1, req_rs2, req_imm};

    always_comb begin
        case (req_unit)
            UNIT_ALU: req_ready = alu_req.ready;
            UNIT_LSU: req_ready = lsu_req.ready;
            UNIT_CSR: req_ready = csr_req.ready;
            default:  req_ready = mul_req.ready;
        endcase
    end

    // Raised on presentation, accepted or not
    assign ebreak = alu_req.valid && (req_op == OP_EBREAK || req_op == OP_ECALL);

endmodule

`default_nettype wire

// File: source/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire                      clk,
    input  wire                      arst_n,
    exe_req_if.slave                 req,
    exe_cmt_if.master                cmt,
    output logic                     branch_valid,
    output logic                     branch_taken,
    output logic [exe_pkg::XLEN-1:0] branch_target
);
    import exe_pkg::*;

    logic            accept;
    logic [XLEN-1:0] result;
    logic            result_wb;
    logic            is_branch;
    logic            taken;

    assign req.ready = !cmt.valid || cmt.ready;
    assign accept    = req.valid && req.ready;

    always_comb begin
        result    = '0;
        result_wb = 1'b1;
        is_branch = 1'b0;
        taken     = 1'b0;
        case (req.op)
            OP_ADD: result = req.rs1 + req.rs2;
            OP_SUB: result = req.rs1 - req.rs2;
            OP_AND: result = req.rs1 & req.rs2;
            OP_OR:  result = req.rs1 | req.rs2;
            OP_XOR: result = req.rs1 ^ req.rs2;
            OP_SLT: result = XLEN'($signed(req.rs1) < $signed(req.rs2));
            OP_SLL: result = req.rs1 << req.rs2[$clog2(XLEN)-1:0];
            OP_SRL: result = req.rs1 >> req.rs2[$clog2(XLEN)-1:0];
            OP_BEQ, OP_BNE: begin
                is_branch = 1'b1;
                taken     = (req.rs1 == req.rs2) ^ (req.op == OP_BNE);
                result_wb = 1'b0;
            end
            OP_JAL: begin
                is_branch = 1'b1;
                taken     = 1'b1;
                result    = req.pc + XLEN'(4);
            end
            // EBREAK, ECALL and anything foreign retire without a write
            default: result_wb = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmt.valid    <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            branch_valid <= accept && is_branch;
            if (accept) begin
                cmt.valid <= 1'b1;
            end else if (cmt.ready) begin
                cmt.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmt.wid       <= req.wid;
            cmt.pc        <= req.pc;
            cmt.rd        <= req.rd;
            cmt.wb        <= result_wb;
            cmt.data      <= result;
            branch_taken  <= taken;
            branch_target <= req.pc + req.imm;
        end
    end

endmodule

`default_nettype wire

// File: source/lsu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_unit (
    input  wire                      clk,
    input  wire                      arst_n,
    exe_req_if.slave                 req,
    exe_cmt_if.master                cmt,
    output logic                     dcache_req_valid,
    output logic                     dcache_req_rw,
    output logic [exe_pkg::XLEN-1:0] dcache_req_addr,
    output logic [exe_pkg::XLEN-1:0] dcache_req_data,
    input  wire                      dcache_req_ready,
    input  wire                      dcache_rsp_valid,
    input  wire  [exe_pkg::XLEN-1:0] dcache_rsp_data
);
    import exe_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_RSP, COMMIT} state_e;

    state_e          state;
    logic            is_store;
    logic [XLEN-1:0] rdata;

    assign req.ready        = (state == IDLE);
    assign dcache_req_valid = (state == REQ);
    assign dcache_req_rw    = is_store;
    assign cmt.valid        = (state == COMMIT);
    assign cmt.wb           = !is_store;
    assign cmt.data         = is_store ? '0 : rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:     if (req.valid) state <= REQ;
                REQ:      if (dcache_req_ready) state <= is_store ? COMMIT : WAIT_RSP;
                WAIT_RSP: if (dcache_rsp_valid) state <= COMMIT;
                COMMIT:   if (cmt.ready) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Request capture and load data
    always_ff @(posedge clk) begin
        if (state == IDLE && req.valid) begin
            cmt.wid         <= req.wid;
            cmt.pc          <= req.pc;
            cmt.rd          <= req.rd;
            is_store        <= (req.op == OP_SW);
            dcache_req_addr <= req.rs1 + req.imm;
            dcache_req_data <= req.rs2;
        end
        if (state == WAIT_RSP && dcache_rsp_valid) begin
            rdata <= dcache_rsp_data;
        end
    end

endmodule

`default_nettype wire

// File: source/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  wire       clk,
    input  wire       arst_n,
    exe_req_if.slave  req,
    exe_cmt_if.master cmt,
    input  wire       cmt_fire
);
    import exe_pkg::*;

    logic            accept;
    logic [11:0]     addr;
    logic [XLEN-1:0] cycle_cnt;
    logic [XLEN-1:0] instret_cnt;
    logic [XLEN-1:0] scratch;
    logic [XLEN-1:0] rd_val;

    assign req.ready = !cmt.valid || cmt.ready;
    assign accept    = req.valid && req.ready;
    assign addr      = req.imm[11:0];
    assign cmt.wb    = 1'b1;

    always_comb begin
        case (addr)
            CSR_CYCLE:   rd_val = cycle_cnt;
            CSR_INSTRET: rd_val = instret_cnt;
            CSR_SCRATCH: rd_val = scratch;
            default:     rd_val = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmt.valid   <= 1'b0;
            cycle_cnt   <= '0;
            instret_cnt <= '0;
            scratch     <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (cmt_fire) begin
                instret_cnt <= instret_cnt + 1'b1;
            end
            // Counters are read-only, only scratch takes writes
            if (accept && addr == CSR_SCRATCH) begin
                scratch <= (req.op == OP_CSRRS) ? (scratch | req.rs1) : req.rs1;
            end
            if (accept) begin
                cmt.valid <= 1'b1;
            end else if (cmt.ready) begin
                cmt.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmt.wid  <= req.wid;
            cmt.pc   <= req.pc;
            cmt.rd   <= req.rd;
            cmt.data <= rd_val;
        end
    end

endmodule

`default_nettype wire

// File: source/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  wire       clk,
    input  wire       arst_n,
    exe_req_if.slave  req,
    exe_cmt_if.master cmt
);
    import exe_pkg::*;

    logic                     advance;
    logic                     s1_valid;
    logic [WID_W-1:0]         s1_wid;
    logic [XLEN-1:0]          s1_pc;
    logic [REG_W-1:0]         s1_rd;
    logic                     s1_high;
    logic [XLEN-1:0]          s1_a;
    logic [XLEN-1:0]          s1_b;
    logic                     s2_high;
    logic signed [2*XLEN-1:0] product;
    logic signed [2*XLEN-1:0] s2_prod;

    // Whole pipe freezes while the output is held
    assign advance   = !cmt.valid || cmt.ready;
    assign req.ready = advance;
    assign product   = $signed(s1_a) * $signed(s1_b);
    assign cmt.wb    = 1'b1;
    assign cmt.data  = s2_high ? s2_prod[2*XLEN-1:XLEN] : s2_prod[XLEN-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            cmt.valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= req.valid;
            cmt.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_wid  <= req.wid;
            s1_pc   <= req.pc;
            s1_rd   <= req.rd;
            s1_high <= (req.op == OP_MULH);
            s1_a    <= req.rs1;
            s1_b    <= req.rs2;
            cmt.wid <= s1_wid;
            cmt.pc  <= s1_pc;
            cmt.rd  <= s1_rd;
            s2_high <= s1_high;
            s2_prod <= product;
        end
    end

endmodule

`default_nettype wire

// File: source/commit_arb.sv
`timescale 1ns/1ps
`default_nettype none

module commit_arb (
    input  wire                       clk,
    input  wire                       arst_n,
    exe_cmt_if.slave                  alu_cmt,
    exe_cmt_if.slave                  lsu_cmt,
    exe_cmt_if.slave                  csr_cmt,
    exe_cmt_if.slave                  mul_cmt,
    output logic                      cmt_valid,
    output logic [exe_pkg::WID_W-1:0] cmt_wid,
    output logic [exe_pkg::XLEN-1:0]  cmt_pc,
    output logic [exe_pkg::REG_W-1:0] cmt_rd,
    output logic                      cmt_wb,
    output logic [exe_pkg::XLEN-1:0]  cmt_data,
    input  wire                       cmt_ready,
    output logic                      cmt_fire
);
    import exe_pkg::*;

    logic [3:0]       src_valid;
    logic [3:0]       src_wb;
    logic [WID_W-1:0] src_wid [4];
    logic [XLEN-1:0]  src_pc [4];
    logic [REG_W-1:0] src_rd [4];
    logic [XLEN-1:0]  src_data [4];
    logic [1:0]       ptr;
    logic [1:0]       gnt;
    logic [1:0]       idx;

    // Source order follows unit_e
    assign src_valid = {mul_cmt.valid, csr_cmt.valid, lsu_cmt.valid, alu_cmt.valid};
    assign src_wb    = {mul_cmt.wb, csr_cmt.wb, lsu_cmt.wb, alu_cmt.wb};
    assign src_wid   = '{alu_cmt.wid, lsu_cmt.wid, csr_cmt.wid, mul_cmt.wid};
    assign src_pc    = '{alu_cmt.pc, lsu_cmt.pc, csr_cmt.pc, mul_cmt.pc};
    assign src_rd    = '{alu_cmt.rd, lsu_cmt.rd, csr_cmt.rd, mul_cmt.rd};
    assign src_data  = '{alu_cmt.data, lsu_cmt.data, csr_cmt.data, mul_cmt.data};

    // First valid source at or after the pointer
    always_comb begin
        cmt_valid = 1'b0;
        gnt       = ptr;
        idx       = ptr;
        for (int i = 0; i < 4; i++) begin
            idx = ptr + 2'(i);
            if (!cmt_valid && src_valid[idx]) begin
                cmt_valid = 1'b1;
                gnt       = idx;
            end
        end
    end

    assign cmt_wid  = src_wid[gnt];
    assign cmt_pc   = src_pc[gnt];
    assign cmt_rd   = src_rd[gnt];
    assign cmt_wb   = src_wb[gnt];
    assign cmt_data = src_data[gnt];
    assign cmt_fire = cmt_valid && cmt_ready;

    assign alu_cmt.ready = cmt_fire && (gnt == 2'd0);
    assign lsu_cmt.ready = cmt_fire && (gnt == 2'd1);
    assign csr_cmt.ready = cmt_fire && (gnt == 2'd2);
    assign mul_cmt.ready = cmt_fire && (gnt == 2'd3);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (cmt_fire) begin
            ptr <= gnt + 2'd1;
        end
    end

endmodule

`default_nettype wire

// File: source/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       req_valid,
    input  wire exe_pkg::unit_e       req_unit,
    input  wire exe_pkg::op_e         req_op,
    input  wire [exe_pkg::WID_W-1:0]  req_wid,
    input  wire [exe_pkg::XLEN-1:0]   req_pc,
    input  wire [exe_pkg::REG_W-1:0]  req_rd,
    input  wire [exe_pkg::XLEN-1:0]   req_rs1,
    input  wire [exe_pkg::XLEN-1:0]   req_rs2,
    input  wire [exe_pkg::XLEN-1:0]   req_imm,
    output logic                      req_ready,
    output logic                      cmt_valid,
    output logic [exe_pkg::WID_W-1:0] cmt_wid,
    output logic [exe_pkg::XLEN-1:0]  cmt_pc,
    output logic [exe_pkg::REG_W-1:0] cmt_rd,
    output logic                      cmt_wb,
    output logic [exe_pkg::XLEN-1:0]  cmt_data,
    input  wire                       cmt_ready,
    output logic                      branch_valid,
    output logic                      branch_taken,
    output logic [exe_pkg::XLEN-1:0]  branch_target,
    output logic                      ebreak,
    output logic                      dcache_req_valid,
    output logic                      dcache_req_rw,
    output logic [exe_pkg::XLEN-1:0]  dcache_req_addr,
    output logic [exe_pkg::XLEN-1:0]  dcache_req_data,
    input  wire                       dcache_req_ready,
    input  wire                       dcache_rsp_valid,
    input  wire  [exe_pkg::XLEN-1:0]  dcache_rsp_data
);

    exe_req_if alu_req ();
    exe_req_if lsu_req ();
    exe_req_if csr_req ();
    exe_req_if mul_req ();

    exe_cmt_if alu_cmt ();
    exe_cmt_if lsu_cmt ();
    exe_cmt_if csr_cmt ();
    exe_cmt_if mul_cmt ();

    logic cmt_fire;

    exe_dispatch u_dispatch (
        .req_valid (req_valid),
        .req_unit  (req_unit),
        .req_op    (req_op),
        .req_wid   (req_wid),
        .req_pc    (req_pc),
        .req_rd    (req_rd),
        .req_rs1   (req_rs1),
        .req_rs2   (req_rs2),
        .req_imm   (req_imm),
        .req_ready (req_ready),
        .ebreak    (ebreak),
        .alu_req   (alu_req),
        .lsu_req   (lsu_req),
        .csr_req   (csr_req),
        .mul_req   (mul_req)
    );

    alu_unit u_alu (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (alu_req),
        .cmt           (alu_cmt),
        .branch_valid  (branch_valid),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    lsu_unit u_lsu (
        .clk              (clk),
        .arst_n           (arst_n),
        .req              (lsu_req),
        .cmt              (lsu_cmt),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_req_addr  (dcache_req_addr),
        .dcache_req_data  (dcache_req_data),
        .dcache_req_ready (dcache_req_ready),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_data  (dcache_rsp_data)
    );

    csr_unit u_csr (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (csr_req),
        .cmt      (csr_cmt),
        .cmt_fire (cmt_fire)
    );

    mul_unit u_mul (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mul_req),
        .cmt    (mul_cmt)
    );

    commit_arb u_arb (
        .clk       (clk),
        .arst_n    (arst_n),
        .alu_cmt   (alu_cmt),
        .lsu_cmt   (lsu_cmt),
        .csr_cmt   (csr_cmt),
        .mul_cmt   (mul_cmt),
        .cmt_valid (cmt_valid),
        .cmt_wid   (cmt_wid),
        .cmt_pc    (cmt_pc),
        .cmt_rd    (cmt_rd),
        .cmt_wb    (cmt_wb),
        .cmt_data  (cmt_data),
        .cmt_ready (cmt_ready),
        .cmt_fire  (cmt_fire)
    );

endmodule

`default_nettype wire

// File: sim/tb_execute.sv
`timescale 1ns/1ps
`default_nettype none

module tb_execute;
    import exe_pkg::*;

    localparam int MAX_ENTRIES = 32;
    localparam int TIMEOUT     = 200;

    logic             clk;
    logic             arst_n;
    logic             req_valid;
    unit_e            req_unit;
    op_e              req_op;
    logic [WID_W-1:0] req_wid;
    logic [XLEN-1:0]  req_pc;
    logic [REG_W-1:0] req_rd;
    logic [XLEN-1:0]  req_rs1;
    logic [XLEN-1:0]  req_rs2;
    logic [XLEN-1:0]  req_imm;
    logic             req_ready;
    logic             cmt_valid;
    logic [WID_W-1:0] cmt_wid;
    logic [XLEN-1:0]  cmt_pc;
    logic [REG_W-1:0] cmt_rd;
    logic             cmt_wb;
    logic [XLEN-1:0]  cmt_data;
    logic             cmt_ready;
    logic             branch_valid;
    logic             branch_taken;
    logic [XLEN-1:0]  branch_target;
    logic             ebreak;
    logic             dcache_req_valid;
    logic             dcache_req_rw;
    logic [XLEN-1:0]  dcache_req_addr;
    logic [XLEN-1:0]  dcache_req_data;
    logic             dcache_req_ready;
    logic             dcache_rsp_valid;
    logic [XLEN-1:0]  dcache_rsp_data;

    // Stimulus table, one row per request
    unit_e       e_unit [MAX_ENTRIES];
    op_e         e_op [MAX_ENTRIES];
    logic [31:0] e_wid [MAX_ENTRIES];
    logic [31:0] e_pc [MAX_ENTRIES];
    logic [31:0] e_rd [MAX_ENTRIES];
    logic [31:0] e_rs1 [MAX_ENTRIES];
    logic [31:0] e_rs2 [MAX_ENTRIES];
    logic [31:0] e_imm [MAX_ENTRIES];
    logic [31:0] e_wb [MAX_ENTRIES];
    logic [31:0] e_data [MAX_ENTRIES];
    logic [31:0] e_taken [MAX_ENTRIES];
    logic [31:0] e_target [MAX_ENTRIES];
    logic [31:0] instret_exp [MAX_ENTRIES];
    int          n_entries = 0;

    // Scoreboard indexed by rd
    int          rd_entry [32];
    logic        rd_expected [32];
    logic        rd_seen [32];
    int          commits_seen = 0;
    logic [31:0] last_cycle = 0;
    logic        branch_due = 1'b0;
    int          due_idx = 0;
    int          cur = 0;

    logic [31:0] mem [64];
    integer      seed = 32'hdc97;
    int          bus_cyc = 0;
    logic        rsp_pend = 1'b0;
    int          rsp_wait = 0;
    logic [31:0] rsp_word = 0;

    execute u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s (got %h, expected %h)", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic logic is_branch_op(input int i);
        return e_unit[i] == UNIT_ALU && (e_op[i] == OP_BEQ || e_op[i] == OP_BNE
            || e_op[i] == OP_JAL);
    endfunction

    // Rows that the stimulus marks as a trap request
    function automatic logic is_trap_row(input int i);
        return e_unit[i] == UNIT_ALU && (e_op[i] == OP_EBREAK || e_op[i] == OP_ECALL);
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] f [12];
        fd = $fopen("sim/execute_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/execute_stim.txt");
            stop_with_failure();
        end
        for (int r = 0; r < 32; r++) begin
            rd_expected[r] = 1'b0;
            rd_seen[r]     = 1'b0;
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#") begin
                rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                             f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
                if (rc == 12) begin
                    check_eq(rd_expected[f[4][4:0]], 1'b0, "rd unique in stimulus");
                    e_unit[n_entries]   = unit_e'(f[0][1:0]);
                    e_op[n_entries]     = op_e'(f[1][4:0]);
                    e_wid[n_entries]    = f[2];
                    e_pc[n_entries]     = f[3];
                    e_rd[n_entries]     = f[4];
                    e_rs1[n_entries]    = f[5];
                    e_rs2[n_entries]    = f[6];
                    e_imm[n_entries]    = f[7];
                    e_wb[n_entries]     = f[8];
                    e_data[n_entries]   = f[9];
                    e_taken[n_entries]  = f[10];
                    e_target[n_entries] = f[11];
                    rd_entry[f[4][4:0]]    = n_entries;
                    rd_expected[f[4][4:0]] = 1'b1;
                    n_entries++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_commit();
        int k;
        check_eq(rd_expected[cmt_rd], 1'b1, "commit rd present in stimulus");
        check_eq(rd_seen[cmt_rd], 1'b0, "rd committed only once");
        k = rd_entry[cmt_rd];
        check_eq(cmt_pc, e_pc[k], "commit pc");
        check_eq(cmt_wid, e_wid[k][WID_W-1:0], "commit wid");
        check_eq(cmt_wb, e_wb[k][0], "commit wb");
        if (e_unit[k] == UNIT_CSR && e_imm[k][11:0] == CSR_INSTRET) begin
            check_eq(cmt_data, instret_exp[k], "instret read");
        end else if (e_unit[k] == UNIT_CSR && e_imm[k][11:0] == CSR_CYCLE) begin
            check_eq(cmt_data > last_cycle, 1'b1, "cycle read increasing");
            last_cycle = cmt_data;
        end else if (e_wb[k][0]) begin
            check_eq(cmt_data, e_data[k], "commit data");
        end
        rd_seen[cmt_rd] = 1'b1;
        commits_seen++;
    endtask

    // Monitor samples at the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (arst_n) begin
            check_eq(ebreak, req_valid && is_trap_row(cur), "ebreak flag");
            check_eq(branch_valid, branch_due, "branch strobe");
            if (branch_due) begin
                check_eq(branch_taken, e_taken[due_idx][0], "branch taken");
                check_eq(branch_target, e_target[due_idx], "branch target");
            end
            branch_due = req_valid && req_ready && is_branch_op(cur);
            due_idx    = cur;
            if (cmt_valid && cmt_ready) begin
                check_commit();
            end
        end
    end

    // Data-cache model and commit back-pressure share one random stream
    initial begin
        cmt_ready        = 1'b0;
        dcache_req_ready = 1'b0;
        dcache_rsp_valid = 1'b0;
        dcache_rsp_data  = '0;
        for (int k = 0; k < 64; k++) begin
            mem[k] = 32'h5a000000 ^ (k * 32'h00010004);
        end
        forever begin
            @(posedge clk);
            if (dcache_req_valid && dcache_req_ready) begin
                if (dcache_req_rw) begin
                    mem[dcache_req_addr[7:2]] = dcache_req_data;
                end else begin
                    rsp_pend = 1'b1;
                    rsp_wait = 1 + ($unsigned($random(seed)) % 4);
                    rsp_word = mem[dcache_req_addr[7:2]];
                end
            end
            #1;
            dcache_rsp_valid = 1'b0;
            if (rsp_pend) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    dcache_rsp_valid = 1'b1;
                    dcache_rsp_data  = rsp_word;
                    rsp_pend         = 1'b0;
                end
            end
            dcache_req_ready = $random(seed) & 1;
            // A long stall window, otherwise ready three times out of four
            if (bus_cyc >= 50 && bus_cyc < 80) begin
                cmt_ready = 1'b0;
            end else begin
                cmt_ready = ($random(seed) & 3) != 0;
            end
            bus_cyc++;
        end
    end

    task automatic present(input int i);
        cur       = i;
        req_valid = 1'b1;
        req_unit  = e_unit[i];
        req_op    = e_op[i];
        req_wid   = e_wid[i][WID_W-1:0];
        req_pc    = e_pc[i];
        req_rd    = e_rd[i][REG_W-1:0];
        req_rs1   = e_rs1[i];
        req_rs2   = e_rs2[i];
        req_imm   = e_imm[i];
    endtask

    task automatic wait_accept(input int i);
        int t;
        t = 0;
        @(posedge clk);
        while (!req_ready) begin
            t++;
            if (t >= TIMEOUT) begin
                $display("Timeout: request %0d was not accepted in %0d cycles", i, TIMEOUT);
                stop_with_failure();
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_commits(input int count, input string what);
        int t;
        t = 0;
        while (commits_seen != count) begin
            t++;
            if (t >= TIMEOUT) begin
                $display("Timeout: %s, %0d of %0d commits seen", what, commits_seen, count);
                stop_with_failure();
            end
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_unit  = UNIT_ALU;
        req_op    = OP_ADD;
        req_wid   = '0;
        req_pc    = '0;
        req_rd    = '0;
        req_rs1   = '0;
        req_rs2   = '0;
        req_imm   = '0;
        load_stimulus();
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            // CSR reads go out with the pipeline drained
            if (e_unit[i] == UNIT_CSR) begin
                wait_commits(i, "draining before a CSR request");
            end
            instret_exp[i] = commits_seen;
            present(i);
            wait_accept(i);
            #1 req_valid = 1'b0;
        end
        wait_commits(n_entries, "waiting for the final commits");
        // Quiet period so a late duplicate commit is still caught
        repeat (10) @(posedge clk);
        if (commits_seen == n_entries && n_entries > 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Saw %0d commits for %0d stimulus rows", commits_seen, n_entries);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: sim/execute_stim.txt
# unit op wid pc rd rs1 rs2 imm exp_wb exp_data exp_taken exp_target (all hex)
# unit 0 alu, 1 lsu, 2 csr, 3 mul; op follows op_e; counter reads carry data 0
0 0 0 00001000 01 00000005 00000007 00000000 1 0000000c 0 00000000
0 1 1 00001004 02 00000003 00000005 00000000 1 fffffffe 0 00000000
0 2 2 00001008 03 f0f0f0f0 ff00ff00 00000000 1 f000f000 0 00000000
0 3 3 0000100c 04 12340000 00005678 00000000 1 12345678 0 00000000
0 4 0 00001010 05 aaaa5555 ffff0000 00000000 1 55555555 0 00000000
0 5 1 00001014 06 ffffffff 00000001 00000000 1 00000001 0 00000000
0 6 2 00001018 07 00000003 00000004 00000000 1 00000030 0 00000000
0 7 3 0000101c 08 80000000 0000001f 00000000 1 00000001 0 00000000
0 8 0 00001020 09 00000011 00000011 00000040 0 00000000 1 00001060
0 9 1 00001024 0a 00000011 00000011 fffffff0 0 00000000 0 00001014
0 a 2 00001028 0b 00000000 00000000 00000100 1 0000102c 1 00001128
0 b 3 0000102c 0c 00000000 00000000 00000000 0 00000000 0 00000000
0 c 0 00001030 0d 00000000 00000000 00000000 0 00000000 0 00000000
1 e 1 00002000 0e 00000010 cafef00d 00000008 0 00000000 0 00000000
1 d 1 00002004 0f 00000008 00000000 00000010 1 cafef00d 0 00000000
1 e 2 00002008 10 00000040 0badbeef 00000004 0 00000000 0 00000000
1 d 2 0000200c 11 00000044 00000000 00000000 1 0badbeef 0 00000000
3 11 0 00003000 12 00000007 fffffffd 00000000 1 ffffffeb 0 00000000
3 12 0 00003004 13 00000007 fffffffd 00000000 1 ffffffff 0 00000000
3 11 1 00003008 14 00010000 00010000 00000000 1 00000000 0 00000000
3 12 1 0000300c 15 00010000 00010000 00000000 1 00000001 0 00000000
3 12 2 00003010 16 80000000 80000000 00000000 1 40000000 0 00000000
2 f 0 00004000 17 0000000f 00000000 00000340 1 00000000 0 00000000
2 10 0 00004004 18 000000f0 00000000 00000340 1 0000000f 0 00000000
2 10 0 00004008 19 00000000 00000000 00000340 1 000000ff 0 00000000
2 10 1 0000400c 1a 00000000 00000000 00000c02 1 00000000 0 00000000
2 10 1 00004010 1b 00000000 00000000 00000c00 1 00000000 0 00000000
2 10 1 00004014 1c 00000000 00000000 00000c00 1 00000000 0 00000000
0 0 0 00001034 1d 7fffffff 00000001 00000000 1 80000000 0 00000000

// File: list.f
source/exe_pkg.sv
source/exe_if.sv
source/exe_dispatch.sv
source/alu_unit.sv
source/lsu_unit.sv
source/csr_unit.sv
source/mul_unit.sv
source/commit_arb.sv
source/execute.sv
sim/tb_execute.sv

// File: run.sh
#!/bin/sh
# Build the execute-stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_execute -f list.f -o tb_execute
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_execute 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
